//--- common/soc_macros.svh
/*
  Address map and sizes of the memory path
  All addresses are byte addresses, the low three bits are ignored
*/

`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

////////////////////////////////////////
// Widths
////////////////////////////////////////

`define SOC_DATA_W 64
`define SOC_ADDR_W 32
`define SOC_STRB_W (`SOC_DATA_W / 8)

// L2 bank geometry, one bank of 64-bit words
`define SOC_L2_WORDS 1024
`define SOC_L2_IDX_W ($clog2(`SOC_L2_WORDS))

////////////////////////////////////////
// Address map
////////////////////////////////////////

// DRAM window spans SOC_L2_WORDS * 8 bytes from the base
`define SOC_DRAM_BASE 32'h8000_0000

`define SOC_CTRL_BASE 32'hD000_0000
`define SOC_CTRL_LEN 32'h0000_1000

// Register offsets inside the control window
`define SOC_CTRL_EXIT_OFS 32'h0000_0000
`define SOC_CTRL_CNT_EN_OFS 32'h0000_0008

`endif

//--- common/soc_pkg.sv
/*
  Shared types of the memory path
  Widths come from the macro header
*/

`include "soc_macros.svh"

package soc_pkg;

  typedef logic [`SOC_DATA_W-1:0] soc_data_t;
  typedef logic [`SOC_ADDR_W-1:0] soc_addr_t;
  typedef logic [`SOC_STRB_W-1:0] soc_strb_t;
  typedef logic [`SOC_L2_IDX_W-1:0] l2_idx_t;

  // Where a request goes after address decode
  typedef enum logic [1:0] {
    TGT_L2   = 2'd0,
    TGT_CTRL = 2'd1,
    TGT_NONE = 2'd2
  } soc_tgt_e;

  // Control register index
  typedef enum logic {
    REG_EXIT   = 1'b0,
    REG_CNT_EN = 1'b1
  } ctrl_reg_e;

  // Byte-enable merge of new data into an old word
  function automatic soc_data_t be_merge(soc_data_t old_word, soc_data_t new_word,
                                         soc_strb_t be);
    soc_data_t res;
    res = old_word;
    for (int b = 0; b < `SOC_STRB_W; b++) begin
      if (be[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

endpackage : soc_pkg

//--- hw/soc_router.sv
/*
  Address decoder and response mux for a single master
  Every request is taken in its cycle, no back-pressure
  Unmapped addresses answer with err_o high and zero data
*/

`timescale 1ns/1ps

`include "soc_macros.svh"

module soc_router import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Master side
  input  logic      req_i,
  input  logic      we_i,
  input  soc_addr_t addr_i,
  input  soc_data_t wdata_i,
  input  soc_strb_t be_i,
  output logic      rvalid_o,
  output soc_data_t rdata_o,
  output logic      err_o,
  // L2 bank
  output logic      bank_req_o,
  output logic      bank_we_o,
  output l2_idx_t   bank_idx_o,
  output soc_data_t bank_wdata_o,
  output soc_strb_t bank_be_o,
  input  soc_data_t bank_rdata_i,
  // Control registers
  output logic      reg_req_o,
  output logic      reg_we_o,
  output ctrl_reg_e reg_sel_o,
  output soc_data_t reg_wdata_o,
  output soc_strb_t reg_be_o,
  input  soc_data_t reg_rdata_i
);

  localparam soc_addr_t DRAM_LEN = soc_addr_t'(`SOC_L2_WORDS * 8);

  soc_addr_t dram_ofs;
  soc_addr_t ctrl_ofs;
  soc_addr_t ctrl_word;
  soc_tgt_e  tgt;
  soc_tgt_e  tgt_q;
  logic      rd_q;
  logic      rvalid_q;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  // Offsets wrap below the base, so one compare per window is enough
  assign dram_ofs  = addr_i - `SOC_DRAM_BASE;
  assign ctrl_ofs  = addr_i - `SOC_CTRL_BASE;
  assign ctrl_word = {ctrl_ofs[`SOC_ADDR_W-1:3], 3'b000};

  always_comb begin
    tgt       = TGT_NONE;
    reg_sel_o = REG_EXIT;
    if (dram_ofs < DRAM_LEN) begin
      tgt = TGT_L2;
    end else if (ctrl_ofs < `SOC_CTRL_LEN) begin
      if (ctrl_word == `SOC_CTRL_EXIT_OFS) begin
        tgt = TGT_CTRL;
      end else if (ctrl_word == `SOC_CTRL_CNT_EN_OFS) begin
        tgt       = TGT_CTRL;
        reg_sel_o = REG_CNT_EN;
      end
    end
  end

  assign bank_req_o   = req_i & (tgt == TGT_L2);
  assign bank_we_o    = we_i;
  assign bank_idx_o   = dram_ofs[`SOC_L2_IDX_W+2:3];
  assign bank_wdata_o = wdata_i;
  assign bank_be_o    = be_i;

  assign reg_req_o   = req_i & (tgt == TGT_CTRL);
  assign reg_we_o    = we_i;
  assign reg_wdata_o = wdata_i;
  assign reg_be_o    = be_i;

  ////////////////////////////////////////
  // Response
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      rd_q     <= 1'b0;
      tgt_q    <= TGT_NONE;
    end else begin
      rvalid_q <= req_i;
      rd_q     <= req_i & ~we_i;
      tgt_q    <= tgt;
    end
  end

  // Writes and unmapped reads return zero
  always_comb begin
    rdata_o = '0;
    if (rd_q) begin
      case (tgt_q)
        TGT_L2:   rdata_o = bank_rdata_i;
        TGT_CTRL: rdata_o = reg_rdata_i;
        default:  rdata_o = '0;
      endcase
    end
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = rvalid_q & (tgt_q == TGT_NONE);

endmodule : soc_router

//--- hw/l2_mem/l2_bank.sv
/*
  Single-port L2 bank, one-cycle read latency
  Contents are undefined until written
*/

`timescale 1ns/1ps

`include "soc_macros.svh"

module l2_bank import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      req_i,
  input  logic      we_i,
  input  l2_idx_t   idx_i,
  input  soc_data_t wdata_i,
  input  soc_strb_t be_i,
  output soc_data_t rdata_o
);

  // Word array, behaves like an SRAM macro
  soc_data_t mem [`SOC_L2_WORDS];

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  // Only enabled bytes change
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem[idx_i] <= be_merge(mem[idx_i], wdata_i, be_i);
    end
  end

  ////////////////////////////////////////
  // Read port
  ////////////////////////////////////////

  // Addressed word is registered on every request, old data on a write
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= mem[idx_i];
    end
  end

endmodule : l2_bank

//--- hw/ctrl_regs/ctrl_regs.sv
/*
  Exit code and hardware-counter enable registers
  Reads are registered, a read in a write cycle sees the old value
*/

`timescale 1ns/1ps

module ctrl_regs import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      req_i,
  input  logic      we_i,
  input  ctrl_reg_e sel_i,
  input  soc_data_t wdata_i,
  input  soc_strb_t be_i,
  output soc_data_t rdata_o,
  output soc_data_t exit_o,
  output soc_data_t hw_cnt_en_o
);

  soc_data_t exit_q;
  soc_data_t cnt_en_q;
  soc_data_t rdata_q;

  ////////////////////////////////////////
  // Register file
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_q   <= '0;
      cnt_en_q <= '0;
    end else if (req_i && we_i) begin
      case (sel_i)
        REG_EXIT:   exit_q   <= be_merge(exit_q, wdata_i, be_i);
        REG_CNT_EN: cnt_en_q <= be_merge(cnt_en_q, wdata_i, be_i);
      endcase
    end
  end

  ////////////////////////////////////////
  // Read path
  ////////////////////////////////////////

  // Selected register is captured on every request
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= (sel_i == REG_CNT_EN) ? cnt_en_q : exit_q;
    end
  end

  assign rdata_o     = rdata_q;
  assign exit_o      = exit_q;
  assign hw_cnt_en_o = cnt_en_q;

endmodule : ctrl_regs

//--- hw/mem_soc.sv
/*
  Memory path top level, one master, one L2 bank, control registers
  Response follows each request by exactly one cycle
*/

`timescale 1ns/1ps

module mem_soc import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      req_i,
  input  logic      we_i,
  input  soc_addr_t addr_i,
  input  soc_data_t wdata_i,
  input  soc_strb_t be_i,
  output logic      rvalid_o,
  output soc_data_t rdata_o,
  output logic      err_o,
  output soc_data_t exit_o,
  output soc_data_t hw_cnt_en_o
);

  // Router to L2 bank
  logic      bank_req;
  logic      bank_we;
  l2_idx_t   bank_idx;
  soc_data_t bank_wdata;
  soc_strb_t bank_be;
  soc_data_t bank_rdata;

  // Router to control registers
  logic      reg_req;
  logic      reg_we;
  ctrl_reg_e reg_sel;
  soc_data_t reg_wdata;
  soc_strb_t reg_be;
  soc_data_t reg_rdata;

  soc_router i_router (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .be_i        (be_i),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o),
    .err_o       (err_o),
    .bank_req_o  (bank_req),
    .bank_we_o   (bank_we),
    .bank_idx_o  (bank_idx),
    .bank_wdata_o(bank_wdata),
    .bank_be_o   (bank_be),
    .bank_rdata_i(bank_rdata),
    .reg_req_o   (reg_req),
    .reg_we_o    (reg_we),
    .reg_sel_o   (reg_sel),
    .reg_wdata_o (reg_wdata),
    .reg_be_o    (reg_be),
    .reg_rdata_i (reg_rdata)
  );

  l2_bank i_l2_bank (
    .clk_i  (clk_i),
    .req_i  (bank_req),
    .we_i   (bank_we),
    .idx_i  (bank_idx),
    .wdata_i(bank_wdata),
    .be_i   (bank_be),
    .rdata_o(bank_rdata)
  );

  ctrl_regs i_ctrl_regs (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (reg_req),
    .we_i       (reg_we),
    .sel_i      (reg_sel),
    .wdata_i    (reg_wdata),
    .be_i       (reg_be),
    .rdata_o    (reg_rdata),
    .exit_o     (exit_o),
    .hw_cnt_en_o(hw_cnt_en_o)
  );

endmodule : mem_soc

//--- testbench/mem_soc_assertions.sv
/*
  Response timing checks, bound into every mem_soc instance
  Checks are off while rst_n_i is low
*/

`timescale 1ns/1ps

module mem_soc_assertions import soc_pkg::*; (
  input logic      clk_i,
  input logic      rst_n_i,
  input logic      req_i,
  input logic      rvalid_o,
  input soc_data_t rdata_o,
  input logic      err_o,
  input soc_data_t exit_o
);

  // One response per request, one cycle later
  a_rvalid_follows_req: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) rvalid_o == $past(req_i)
  ) else $error("rvalid_o does not follow req_i by one cycle");

  // An error response is a valid response with no data
  a_err_response: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) err_o |-> rvalid_o && rdata_o == '0
  ) else $error("err_o high without rvalid_o or with nonzero rdata_o");

  // Exit code moves only as the result of a request
  a_exit_after_req: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) (exit_o != $past(exit_o)) |-> $past(req_i)
  ) else $error("exit_o changed without a request in the cycle before");

endmodule : mem_soc_assertions

bind mem_soc mem_soc_assertions u_assertions (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .req_i   (req_i),
  .rvalid_o(rvalid_o),
  .rdata_o (rdata_o),
  .err_o   (err_o),
  .exit_o  (exit_o)
);

//--- testbench/tb_mem_soc.sv
/*
  Random traffic testbench for mem_soc with a reference model
  L2 bytes are compared only after they were written once
*/

`timescale 1ns/1ps

`include "soc_macros.svh"

module tb_mem_soc import soc_pkg::*; #(
  parameter int SEED = 9937
);

  localparam int NUM_REQ = 3000;
  localparam int TIMEOUT_CYCLES = 2 * NUM_REQ + 100;

  logic      clk_i;
  logic      rst_n_i;
  logic      req_i;
  logic      we_i;
  soc_addr_t addr_i;
  soc_data_t wdata_i;
  soc_strb_t be_i;
  logic      rvalid_o;
  soc_data_t rdata_o;
  logic      err_o;
  soc_data_t exit_o;
  soc_data_t hw_cnt_en_o;

  // Reference model, written holds one bit per byte ever written
  soc_data_t shadow [`SOC_L2_WORDS];
  soc_strb_t written [`SOC_L2_WORDS];
  soc_data_t exit_model;
  soc_data_t cnt_en_model;

  // Expected response of the request in flight, and of the one being issued
  logic      cur_valid, nxt_valid;
  logic      cur_err, nxt_err;
  soc_data_t cur_rdata, nxt_rdata;
  soc_data_t cur_mask, nxt_mask;
  soc_data_t cur_exit, nxt_exit;
  soc_data_t cur_cnt_en, nxt_cnt_en;
  string     cur_name, nxt_name;

  integer seed;
  int     errors;
  int     checks;
  int     cycles;

  mem_soc dut0 (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (req_i),
    .we_i       (we_i),
    .addr_i     (addr_i),
    .wdata_i    (wdata_i),
    .be_i       (be_i),
    .rvalid_o   (rvalid_o),
    .rdata_o    (rdata_o),
    .err_o      (err_o),
    .exit_o     (exit_o),
    .hw_cnt_en_o(hw_cnt_en_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Model helpers and compare tasks
  ////////////////////////////////////////

  function automatic soc_data_t byte_mask(soc_strb_t be);
    soc_data_t m;
    m = '0;
    for (int b = 0; b < `SOC_STRB_W; b++) begin
      m[8*b +: 8] = {8{be[b]}};
    end
    return m;
  endfunction

  function automatic soc_data_t merge_bytes(soc_data_t old_word, soc_data_t new_word,
                                            soc_strb_t be);
    soc_data_t m;
    m = byte_mask(be);
    return (old_word & ~m) | (new_word & m);
  endfunction

  task automatic check_data(input string name, input soc_data_t exp, input soc_data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_response();
    check_flag({cur_name, " rvalid"}, cur_valid, rvalid_o);
    check_flag({cur_name, " err"}, cur_err, err_o);
    if (cur_valid) begin
      check_data({cur_name, " rdata"}, cur_rdata & cur_mask, rdata_o & cur_mask);
    end
    check_data({cur_name, " exit"}, cur_exit, exit_o);
    check_data({cur_name, " cnt_en"}, cur_cnt_en, hw_cnt_en_o);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic issue_request();
    integer    r0;
    integer    r1;
    int        kind;
    l2_idx_t   idx;
    soc_addr_t addr;
    soc_data_t data;
    soc_strb_t be;
    logic      wr;
    ctrl_reg_e sel;
    r0   = $random(seed);
    r1   = $random(seed);
    kind = $unsigned($random(seed)) % 12;
    data = {$random(seed), $random(seed)};
    be   = r0[15:8];
    wr   = r0[16];
    // Small index range so reads mostly land on written words
    idx  = l2_idx_t'(r1[4:0]);
    sel  = r1[8] ? REG_CNT_EN : REG_EXIT;
    addr = `SOC_DRAM_BASE + (soc_addr_t'(idx) << 3) + soc_addr_t'(r1[7:5]);
    nxt_valid = 1'b1;
    nxt_err   = 1'b0;
    nxt_rdata = '0;
    nxt_mask  = '1;
    if (kind < 6) begin
      nxt_name = wr ? "l2_write" : "l2_read";
      if (wr) begin
        shadow[idx]  = merge_bytes(shadow[idx], data, be);
        written[idx] = written[idx] | be;
      end else begin
        nxt_rdata = shadow[idx];
        nxt_mask  = byte_mask(written[idx]);
      end
    end else if (kind < 8) begin
      nxt_name = wr ? "ctrl_write" : "ctrl_read";
      addr = `SOC_CTRL_BASE + soc_addr_t'(r1[7:5]) +
             ((sel == REG_CNT_EN) ? `SOC_CTRL_CNT_EN_OFS : `SOC_CTRL_EXIT_OFS);
      if (wr && sel == REG_CNT_EN) cnt_en_model = merge_bytes(cnt_en_model, data, be);
      if (wr && sel == REG_EXIT) exit_model = merge_bytes(exit_model, data, be);
      if (!wr) nxt_rdata = (sel == REG_CNT_EN) ? cnt_en_model : exit_model;
    end else if (kind < 11) begin
      nxt_name = "unmapped";
      nxt_err  = 1'b1;
      if (kind == 8) addr = `SOC_CTRL_BASE + 32'h10 + (soc_addr_t'(r1[7:0]) << 3);
      if (kind == 9) addr = 32'h4000_0000 + soc_addr_t'(r1[15:0]);
      // First bytes past the end of the DRAM window
      if (kind == 10) addr = `SOC_DRAM_BASE + `SOC_L2_WORDS * 8 + soc_addr_t'(r1[7:0]);
    end else begin
      nxt_name  = "idle";
      nxt_valid = 1'b0;
    end
    nxt_exit   = exit_model;
    nxt_cnt_en = cnt_en_model;
    req_i   <= nxt_valid;
    we_i    <= wr;
    addr_i  <= addr;
    wdata_i <= data;
    be_i    <= be;
  endtask

  initial begin
    rst_n_i = 1'b0;
    req_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    be_i    = '0;
    seed    = SEED;
    errors  = 0;
    checks  = 0;
    exit_model   = '0;
    cnt_en_model = '0;
    for (int i = 0; i < `SOC_L2_WORDS; i++) begin
      written[i] = '0;
    end
    cur_valid  = 1'b0;
    cur_err    = 1'b0;
    cur_rdata  = '0;
    cur_mask   = '1;
    cur_exit   = '0;
    cur_cnt_en = '0;
    cur_name   = "reset";
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_response();
    for (int n = 0; n <= NUM_REQ; n++) begin
      @(posedge clk_i);
      if (n < NUM_REQ) begin
        issue_request();
      end else begin
        nxt_name  = "drain";
        nxt_valid = 1'b0;
        nxt_err   = 1'b0;
        req_i <= 1'b0;
      end
      @(negedge clk_i);
      check_response();
      cur_valid  = nxt_valid;
      cur_err    = nxt_err;
      cur_rdata  = nxt_rdata;
      cur_mask   = nxt_mask;
      cur_exit   = nxt_exit;
      cur_cnt_en = nxt_cnt_en;
      cur_name   = nxt_name;
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Run limit
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule : tb_mem_soc

//--- mem_soc.f
+incdir+common
common/soc_pkg.sv
hw/soc_router.sv
hw/l2_mem/l2_bank.sv
hw/ctrl_regs/ctrl_regs.sv
hw/mem_soc.sv
testbench/mem_soc_assertions.sv
testbench/tb_mem_soc.sv

//--- Makefile
# Verilator build and run for the mem_soc testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_soc
LINT_TOP  ?= mem_soc
SEED      ?= 9937
FILELIST  ?= mem_soc.f
OBJ_DIR   ?= obj_dir

VFLAGS ?= --timing --assert --timescale 1ns/1ps

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) -Mdir $(OBJ_DIR) -o V$(TOP)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
